/* Bender.yml */
package:
  name: usb_ft1248

sources:
  # RTL in compile order
  - logic/usb_pkg.sv
  - logic/byte_fifo.sv
  - logic/ft1248_engine.sv
  - logic/usb_ft1248.sv

  # testbench
  - target: simulation
    files:
      - sim/clock_gen.sv
      - sim/ft1248_device_model.sv
      - sim/tb_usb_ft1248.sv

/* logic/byte_fifo.sv */
`timescale 1ns/1ns

module byte_fifo #(
    parameter int DEPTH_BITS = usb_pkg::FIFO_DEPTH_BITS
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                flush,

    input  logic                read,
    input  logic                write,
    input  usb_pkg::byte_t      wdata,

    output logic                empty,
    output logic                full,
    output usb_pkg::byte_t      rdata,
    output logic [DEPTH_BITS:0] count
);

    import usb_pkg::*;

    localparam int DEPTH = 1 << DEPTH_BITS;

    byte_t mem [DEPTH];

    // pointers carry one extra wrap bit above the address.
    logic [DEPTH_BITS:0] wr_ptr;
    logic [DEPTH_BITS:0] rd_ptr;

    logic [DEPTH_BITS-1:0] wr_addr;
    logic [DEPTH_BITS-1:0] rd_addr;

    logic do_write;
    logic do_read;

    assign wr_addr = wr_ptr[DEPTH_BITS-1:0];
    assign rd_addr = rd_ptr[DEPTH_BITS-1:0];

    // a write into a full buffer or a read from an empty one is dropped.
    assign do_write = write && !full;
    assign do_read  = read && !empty;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_addr] <= wdata;
        end
    end

    assign rdata = mem[rd_addr];   // head byte, first word fall through.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pointers and flags
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    assign count = wr_ptr - rd_ptr;
    assign empty = (wr_ptr == rd_ptr);

    // same address but different wrap bits means the writer lapped the reader.
    assign full = (wr_addr == rd_addr) && (wr_ptr[DEPTH_BITS] != rd_ptr[DEPTH_BITS]);

endmodule

/* logic/ft1248_engine.sv */
`timescale 1ns/1ns

module ft1248_engine #(
    parameter int STATUS_POLL_BITS = usb_pkg::STATUS_POLL_BITS
) (
    input  logic           clk,
    input  logic           reset,

    input  logic           fifo_flush,
    input  logic           reset_on_ack,
    input  logic           reset_off_ack,
    output logic           fifo_flush_busy,
    output logic           reset_state,
    output logic           pwrsav,

    output logic           flush,
    input  logic           rx_full,
    output logic           rx_write,
    output usb_pkg::byte_t rx_wdata,
    input  logic           tx_empty,
    output logic           tx_read,
    input  usb_pkg::byte_t tx_rdata,

    input  logic           usb_pwrsav,
    output logic           usb_clk,
    output logic           usb_cs,
    input  logic           usb_miso,
    inout  wire [7:0]      usb_miosi
);

    import usb_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_select,
        st_command,
        st_status,
        st_data,
        st_deselect
    } state_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pad registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic [1:0] pwrsav_sync;
    logic       ft_pwrsav;       // high while the chip is awake.
    logic       ft_miso;
    byte_t      ft_miosi_in;
    byte_t      ft_miosi_out;
    logic       ft_clk;
    logic       ft_cs;
    logic       ft_oe;
    byte_t      miosi_out;
    logic       usb_oe;

    always_ff @(posedge clk) begin
        pwrsav_sync <= {pwrsav_sync[0], usb_pwrsav};
        ft_pwrsav   <= pwrsav_sync[1];
        ft_miso     <= usb_miso;
        ft_miosi_in <= usb_miosi;
        miosi_out   <= ft_miosi_out;
        if (reset) begin
            usb_clk <= 1'b0;
            usb_cs  <= 1'b1;
            usb_oe  <= 1'b0;
        end else begin
            usb_clk <= ft_clk;
            usb_cs  <= ft_cs;
            usb_oe  <= ft_oe;
        end
    end

    assign usb_miosi = usb_oe ? miosi_out : 8'hzz;
    assign pwrsav    = !ft_pwrsav;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sequencer state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    state_e  state;
    state_e  next_state;
    ft_cmd_e cmd;
    ft_cmd_e next_cmd;
    logic [3:0] phase;

    logic  last_rx_failed;
    logic  last_tx_failed;
    logic  reset_reply;
    logic  status_write_pending;
    logic  rx_accept;
    logic  byte_end;
    byte_t tx_byte;              // byte on the bus during a data write.
    byte_t status_byte;
    logic [STATUS_POLL_BITS-1:0] poll_counter;

    // the chip answers on the last phase of every byte slot.
    assign byte_end = (state == st_data) && phase[3];

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
        cmd <= next_cmd;
        if (reset || (state == st_idle)) begin
            phase <= 4'b0001;
        end else begin
            phase <= {phase[2:0], phase[3]};
        end
    end

    always_ff @(posedge clk) begin
        if (byte_end && (cmd == cmd_read) && !ft_miso) begin
            rx_wdata <= ft_miosi_in;
        end
        if (tx_read) begin
            tx_byte <= tx_rdata;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bookkeeping
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (reset) begin
            fifo_flush_busy      <= 1'b0;
            reset_state          <= 1'b0;
            flush                <= 1'b0;
            rx_write             <= 1'b0;
            last_rx_failed       <= 1'b0;
            last_tx_failed       <= 1'b0;
            reset_reply          <= 1'b0;
            status_write_pending <= 1'b1;   // announce the reply state once.
            poll_counter         <= '0;
        end else begin
            flush    <= 1'b0;
            rx_write <= rx_accept;

            if (fifo_flush) begin
                fifo_flush_busy <= 1'b1;
            end

            if (state == st_idle) begin
                poll_counter <= poll_counter + 1'b1;
                if (fifo_flush_busy) begin
                    fifo_flush_busy <= 1'b0;
                    flush           <= 1'b1;
                    last_rx_failed  <= 1'b0;   // a held byte goes with the flush.
                    last_tx_failed  <= 1'b0;
                end else if (last_rx_failed && !rx_full) begin
                    last_rx_failed <= 1'b0;
                    rx_write       <= 1'b1;
                end
            end

            if (byte_end) begin
                case (cmd)
                    cmd_read: last_rx_failed <= !ft_miso && rx_full;
                    cmd_write: last_tx_failed <= ft_miso;
                    cmd_read_modem_status: begin
                        if (!ft_miso) begin
                            reset_state <= ft_miosi_in[MODEM_RESET_BIT];
                        end
                    end
                    cmd_write_modem_status: begin
                        if (!ft_miso) begin
                            status_write_pending <= 1'b0;
                        end
                    end
                    default: begin
                    end
                endcase
            end

            // a new ack outranks the completion of an older status write.
            if (reset_on_ack) begin
                reset_reply          <= 1'b1;
                status_write_pending <= 1'b1;
            end
            if (reset_off_ack) begin
                reset_reply          <= 1'b0;
                status_write_pending <= 1'b1;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus outputs and FIFO strobes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        status_byte = '0;
        status_byte[MODEM_REPLY_BIT] = reset_reply;

        ft_clk       = 1'b0;
        ft_cs        = (state == st_idle) || (state == st_deselect);
        ft_oe        = 1'b0;
        ft_miosi_out = 8'hff;

        if ((state == st_command) || (state == st_status) || (state == st_data)) begin
            ft_clk = phase[0] || phase[1];
        end
        if (state == st_command) begin
            ft_oe        = 1'b1;
            ft_miosi_out = cmd;
        end
        if ((state == st_data) && (cmd == cmd_write)) begin
            ft_oe        = 1'b1;
            ft_miosi_out = tx_byte;
        end
        if ((state == st_data) && (cmd == cmd_write_modem_status)) begin
            ft_oe        = 1'b1;
            ft_miosi_out = status_byte;
        end
    end

    assign rx_accept = byte_end && !ft_miso && (cmd == cmd_read) && !rx_full;

    // a refused byte stays in tx_byte, so the status slot skips the FIFO read.
    always_comb begin
        tx_read = 1'b0;
        if (phase[3] && !ft_miso && (cmd == cmd_write) && !tx_empty) begin
            if ((state == st_status) && !last_tx_failed) begin
                tx_read = 1'b1;
            end
            if (state == st_data) begin
                tx_read = 1'b1;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // next state and arbitration
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        next_state = state;
        next_cmd   = cmd;

        case (state)
            st_idle: begin
                if (ft_pwrsav && !(fifo_flush || fifo_flush_busy || flush)) begin
                    if (status_write_pending) begin
                        next_state = st_select;
                        next_cmd   = cmd_write_modem_status;
                    end else if (&poll_counter) begin
                        next_state = st_select;
                        next_cmd   = cmd_read_modem_status;
                    end else if (!tx_empty || last_tx_failed) begin
                        next_state = st_select;
                        next_cmd   = cmd_write;
                    end else if (!rx_full) begin
                        next_state = st_select;
                        next_cmd   = cmd_read;
                    end
                end
            end
            st_select: begin
                if (phase[3]) begin
                    next_state = st_command;
                end
            end
            st_command: begin
                if (phase[3]) begin
                    next_state = st_status;
                end
            end
            st_status: begin
                if (phase[3]) begin
                    next_state = ft_miso ? st_deselect : st_data;
                end
            end
            st_data: begin
                if (phase[3]) begin
                    if (ft_miso) begin
                        next_state = st_deselect;
                    end else if (cmd == cmd_read) begin
                        next_state = rx_full ? st_deselect : st_data;
                    end else if (cmd == cmd_write) begin
                        next_state = tx_empty ? st_deselect : st_data;
                    end else begin
                        next_state = st_deselect;   // status commands move one byte.
                    end
                end
            end
            st_deselect: begin
                if (phase[1]) begin
                    next_state = st_idle;
                end
            end
            default: next_state = st_idle;
        endcase
    end

endmodule

/* logic/usb_ft1248.sv */
`timescale 1ns/1ns

module usb_ft1248 #(
    parameter int DEPTH_BITS       = usb_pkg::FIFO_DEPTH_BITS,
    parameter int STATUS_POLL_BITS = usb_pkg::STATUS_POLL_BITS
) (
    input  logic                clk,
    input  logic                reset,

    input  logic                rx_read,
    output logic                rx_empty,
    output usb_pkg::byte_t      rx_rdata,
    output logic [DEPTH_BITS:0] rx_count,

    input  logic                tx_write,
    input  usb_pkg::byte_t      tx_wdata,
    output logic                tx_full,
    output logic [DEPTH_BITS:0] tx_count,

    input  logic                fifo_flush,
    output logic                fifo_flush_busy,
    input  logic                reset_on_ack,
    input  logic                reset_off_ack,
    output logic                reset_state,
    output logic                pwrsav,

    input  logic                usb_pwrsav,
    output logic                usb_clk,
    output logic                usb_cs,
    input  logic                usb_miso,
    inout  wire [7:0]           usb_miosi
);

    import usb_pkg::*;

    logic  flush;
    logic  rx_full;
    logic  rx_write;
    byte_t rx_wdata;
    logic  tx_empty;
    logic  tx_read;
    byte_t tx_rdata;

    // bytes from the chip toward the host side.
    byte_fifo #(
        .DEPTH_BITS(DEPTH_BITS)
    ) rx_fifo (
        .clk(clk),
        .reset(reset),
        .flush(flush),
        .read(rx_read),
        .write(rx_write),
        .wdata(rx_wdata),
        .empty(rx_empty),
        .full(rx_full),
        .rdata(rx_rdata),
        .count(rx_count)
    );

    byte_fifo #(
        .DEPTH_BITS(DEPTH_BITS)
    ) tx_fifo (
        .clk(clk),
        .reset(reset),
        .flush(flush),
        .read(tx_read),
        .write(tx_write),
        .wdata(tx_wdata),
        .empty(tx_empty),
        .full(tx_full),
        .rdata(tx_rdata),
        .count(tx_count)
    );

    ft1248_engine #(
        .STATUS_POLL_BITS(STATUS_POLL_BITS)
    ) engine (
        .clk(clk),
        .reset(reset),
        .fifo_flush(fifo_flush),
        .reset_on_ack(reset_on_ack),
        .reset_off_ack(reset_off_ack),
        .fifo_flush_busy(fifo_flush_busy),
        .reset_state(reset_state),
        .pwrsav(pwrsav),
        .flush(flush),
        .rx_full(rx_full),
        .rx_write(rx_write),
        .rx_wdata(rx_wdata),
        .tx_empty(tx_empty),
        .tx_read(tx_read),
        .tx_rdata(tx_rdata),
        .usb_pwrsav(usb_pwrsav),
        .usb_clk(usb_clk),
        .usb_cs(usb_cs),
        .usb_miso(usb_miso),
        .usb_miosi(usb_miosi)
    );

endmodule

/* logic/usb_pkg.sv */
package usb_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus data
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // one byte as it crosses the FT1248 data bus.
    typedef logic [7:0] byte_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // FT1248 command bytes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // sent on the bus right after chip select falls.
    typedef enum logic [7:0] {
        cmd_write              = 8'h00,   // host bound data bytes.
        cmd_read               = 8'h40,   // device bound data bytes.
        cmd_read_modem_status  = 8'h20,
        cmd_write_modem_status = 8'h60
    } ft_cmd_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // default sizes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // log2 of the byte count each FIFO holds.
    parameter int FIFO_DEPTH_BITS = 4;

    // the idle counter wraps every 2**STATUS_POLL_BITS idle cycles,
    // which triggers a modem-status read.
    parameter int STATUS_POLL_BITS = 5;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // modem status bits
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // host reset state in a status byte read from the chip.
    parameter int MODEM_RESET_BIT = 0;

    // reset reply flag in a status byte written to the chip.
    parameter int MODEM_REPLY_BIT = 5;

endpackage

/* sim.f */
logic/usb_pkg.sv
logic/byte_fifo.sv
logic/ft1248_engine.sv
logic/usb_ft1248.sv
sim/clock_gen.sv
sim/ft1248_device_model.sv
sim/tb_usb_ft1248.sv

/* sim/clock_gen.sv */
`timescale 1ns/1ns

module clock_gen #(
    parameter int HALF_PERIOD  = 2,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;   // released on a falling edge.
    end

endmodule

/* sim/ft1248_device_model.sv */
`timescale 1ns/1ns

module ft1248_device_model (
    input  logic      clk,
    input  logic      usb_clk,
    input  logic      usb_cs,
    output logic      usb_miso,
    inout  wire [7:0] usb_miosi,
    output logic      usb_pwrsav
);

    import usb_pkg::*;

    byte_t source_q[$];          // bytes offered to the bridge.
    byte_t sink_q[$];            // bytes the bridge wrote to the host.
    byte_t status_reg;
    byte_t written_status;
    int    status_writes;
    logic  refuse_alternate;
    logic  refuse_next;
    logic  power_save;

    logic  prev_clk;
    int    slot;                 // bus byte index since chip select fell.
    byte_t cmd;
    logic  accepting;
    logic  drive_en;
    byte_t drive_byte;

    assign usb_miosi = drive_en ? drive_byte : 8'hzz;

    initial begin
        usb_miso         = 1'b1;
        usb_pwrsav       = 1'b1;
        status_reg       = '0;
        written_status   = '0;
        status_writes    = 0;
        refuse_alternate = 1'b0;
        refuse_next      = 1'b1;
        power_save       = 1'b0;
        prev_clk         = 1'b0;
        slot             = 0;
        cmd              = '0;
        accepting        = 1'b0;
        drive_en         = 1'b0;
        drive_byte       = '0;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // controls used by the testbench
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic offer_byte(input byte_t b);
        source_q.push_back(b);
    endtask

    task automatic set_modem_status(input byte_t b);
        status_reg = b;
    endtask

    task automatic set_refuse(input logic on);
        refuse_alternate = on;
        refuse_next      = 1'b1;
    endtask

    task automatic set_power_save(input logic on);
        power_save = on;
    endtask

    function automatic int sink_size();
        return sink_q.size();
    endfunction

    function automatic byte_t sink_byte(input int i);
        return sink_q[i];
    endfunction

    function automatic int source_size();
        return source_q.size();
    endfunction

    function automatic int status_write_count();
        return status_writes;
    endfunction

    function automatic byte_t last_written_status();
        return written_status;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus answers on falling system clock edges
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(negedge clk) begin
        usb_pwrsav = !power_save;   // the pin is low while saving power.
        if (usb_cs) begin
            slot      = 0;
            drive_en  = 1'b0;
            usb_miso  = 1'b1;
            accepting = 1'b0;
        end else if (usb_clk && !prev_clk) begin
            if (slot == 1) begin
                // a read with nothing to offer is refused at status.
                usb_miso = (cmd == cmd_read) && (source_q.size() == 0);
            end else if (slot >= 2) begin
                usb_miso  = 1'b0;
                accepting = 1'b1;
                case (cmd)
                    cmd_read: begin
                        if (source_q.size() == 0) begin
                            usb_miso  = 1'b1;
                            accepting = 1'b0;
                        end else begin
                            drive_byte = source_q.pop_front();
                            drive_en   = 1'b1;
                        end
                    end
                    cmd_read_modem_status: begin
                        drive_byte = status_reg;
                        drive_en   = 1'b1;
                    end
                    cmd_write: begin
                        if (refuse_alternate && refuse_next) begin
                            usb_miso  = 1'b1;
                            accepting = 1'b0;
                        end
                        if (refuse_alternate) begin
                            refuse_next = !refuse_next;
                        end
                    end
                    default: begin
                    end
                endcase
            end
            slot = slot + 1;
        end else if (!usb_clk && prev_clk) begin
            if (slot == 1) begin
                cmd = usb_miosi;
            end else if ((slot >= 3) && accepting) begin
                if (cmd == cmd_write) begin
                    sink_q.push_back(usb_miosi);
                end
                if (cmd == cmd_write_modem_status) begin
                    written_status = usb_miosi;
                    status_writes  = status_writes + 1;
                end
            end
        end
        prev_clk = usb_clk;
    end

endmodule

/* sim/tb_usb_ft1248.sv */
`timescale 1ns/1ns

module tb_usb_ft1248;

    import usb_pkg::*;

    localparam int DEPTH_BITS = 4;
    localparam int RX_DEPTH   = 1 << DEPTH_BITS;
    localparam int TX_DEPTH   = 1 << DEPTH_BITS;
    localparam int BURST      = 40;

    // counts every byte a test moves or queues including the flushed ones.
    localparam int BYTES_TESTED = 3 * BURST + 2 * 8 + (RX_DEPTH + 1) + TX_DEPTH;

    // one idle cycle can be followed by a refused read attempt of 15 cycles.
    localparam int STATUS_LATENCY  = 64 * 16;
    localparam int WATCHDOG_CYCLES = 200 * BYTES_TESTED + 4 * STATUS_LATENCY + 2000;

    logic                clk;
    logic                reset;
    logic                rx_read;
    logic                rx_empty;
    byte_t               rx_rdata;
    logic [DEPTH_BITS:0] rx_count;
    logic                tx_write;
    byte_t               tx_wdata;
    logic                tx_full;
    logic [DEPTH_BITS:0] tx_count;
    logic                fifo_flush;
    logic                fifo_flush_busy;
    logic                reset_on_ack;
    logic                reset_off_ack;
    logic                reset_state;
    logic                pwrsav;
    logic                usb_pwrsav;
    logic                usb_clk;
    logic                usb_cs;
    logic                usb_miso;
    wire [7:0]           usb_miosi;

    logic [31:0] seed;
    byte_t       tx_expect[$];
    byte_t       rx_expect[$];
    logic        quiet_window;   // the bus must stay deselected while this is high.
    int          sink_before;

    clock_gen clocks (
        .clk(clk),
        .reset(reset)
    );

    usb_ft1248 #(
        .DEPTH_BITS(DEPTH_BITS),
        .STATUS_POLL_BITS(usb_pkg::STATUS_POLL_BITS)
    ) dut (
        .clk(clk),
        .reset(reset),
        .rx_read(rx_read),
        .rx_empty(rx_empty),
        .rx_rdata(rx_rdata),
        .rx_count(rx_count),
        .tx_write(tx_write),
        .tx_wdata(tx_wdata),
        .tx_full(tx_full),
        .tx_count(tx_count),
        .fifo_flush(fifo_flush),
        .fifo_flush_busy(fifo_flush_busy),
        .reset_on_ack(reset_on_ack),
        .reset_off_ack(reset_off_ack),
        .reset_state(reset_state),
        .pwrsav(pwrsav),
        .usb_pwrsav(usb_pwrsav),
        .usb_clk(usb_clk),
        .usb_cs(usb_cs),
        .usb_miso(usb_miso),
        .usb_miosi(usb_miosi)
    );

    ft1248_device_model model (
        .clk(clk),
        .usb_clk(usb_clk),
        .usb_cs(usb_cs),
        .usb_miso(usb_miso),
        .usb_miosi(usb_miosi),
        .usb_pwrsav(usb_pwrsav)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checking
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic stop_with_failure();
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected === actual) else begin
            $display("Error: %s expected %0h actual %0h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic check_condition(input logic cond, input string what);
        assert (cond === 1'b1) else begin
            $display("Failure: %s", what);
            stop_with_failure();
        end
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            assert (rx_count <= RX_DEPTH) else begin
                $display("Error: rx occupancy expected at most %0d actual %0d",
                         RX_DEPTH, rx_count);
                stop_with_failure();
            end
            if (quiet_window) begin
                check_condition(usb_cs, "usb_cs fell while the chip was power saving");
                check_value("pwrsav during power saving", 1, pwrsav);
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        stop_with_failure();
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus helpers entered just after a falling edge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic write_tx_byte(input byte_t b);
        while (tx_full) @(negedge clk);
        tx_wdata = b;
        tx_write = 1'b1;
        @(negedge clk);
        tx_write = 1'b0;
    endtask

    task automatic send_tx_random(input int n, input logic record);
        byte_t b;
        for (int i = 0; i < n; i++) begin
            seed = lcg_next(seed);
            b = seed[23:16];
            if (record) begin
                tx_expect.push_back(b);
            end
            write_tx_byte(b);
        end
    endtask

    task automatic offer_rx_random(input int n, input logic record);
        byte_t b;
        for (int i = 0; i < n; i++) begin
            seed = lcg_next(seed);
            b = seed[23:16];
            if (record) begin
                rx_expect.push_back(b);
            end
            model.offer_byte(b);
        end
    endtask

    // the sink holds every byte sent so far, so it is compared whole.
    task automatic check_tx_sink(input string name);
        while (model.sink_size() < tx_expect.size()) @(negedge clk);
        check_value(name, tx_expect.size(), model.sink_size());
        for (int i = 0; i < tx_expect.size(); i++) begin
            check_value(name, tx_expect[i], model.sink_byte(i));
        end
    endtask

    task automatic read_rx_bytes(input string name, input int n);
        int got;
        got = 0;
        while (got < n) begin
            @(negedge clk);
            rx_read = 1'b0;
            if (!rx_empty) begin
                check_value(name, rx_expect.pop_front(), rx_rdata);
                rx_read = 1'b1;
                got++;
            end
        end
        @(negedge clk);
        rx_read = 1'b0;
    endtask

    task automatic enter_power_save();
        model.set_power_save(1'b1);
        while (!pwrsav) @(negedge clk);
        wait_cycles(4);
        while (!usb_cs) @(negedge clk);   // a transfer already begun runs to its end.
    endtask

    task automatic wait_reset_state(input logic level, input string name);
        int cycles;
        cycles = 0;
        while ((reset_state !== level) && (cycles < STATUS_LATENCY)) begin
            @(negedge clk);
            cycles++;
        end
        check_value(name, level, reset_state);
    endtask

    task automatic ack_and_check_reply(input logic on, input string name);
        int    writes;
        byte_t written;
        writes = model.status_write_count();
        reset_on_ack  = on;
        reset_off_ack = !on;
        @(negedge clk);
        reset_on_ack  = 1'b0;
        reset_off_ack = 1'b0;
        while (model.status_write_count() == writes) @(negedge clk);
        written = model.last_written_status();
        check_value(name, on, written[MODEM_REPLY_BIT]);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        rx_read       = 1'b0;
        tx_write      = 1'b0;
        tx_wdata      = '0;
        fifo_flush    = 1'b0;
        reset_on_ack  = 1'b0;
        reset_off_ack = 1'b0;
        quiet_window  = 1'b0;
        sink_before   = 0;
        seed          = 32'hdcd8_6269;
        @(negedge clk);

        // pins and flags as reset leaves them.
        check_value("usb_cs in reset", 1, usb_cs);
        check_value("usb_clk in reset", 0, usb_clk);
        check_condition(usb_miosi === 8'hzz, "usb_miosi was driven during reset");
        check_value("flush busy in reset", 0, fifo_flush_busy);
        check_value("reset state in reset", 0, reset_state);

        wait (!reset);
        wait_cycles(20);

        send_tx_random(BURST, 1'b1);
        check_tx_sink("transmit order");

        model.set_refuse(1'b1);
        send_tx_random(BURST, 1'b1);
        check_tx_sink("refused byte retry");
        model.set_refuse(1'b0);

        // host stays away until the rx FIFO has been full for a while.
        offer_rx_random(BURST, 1'b1);
        while (rx_count != RX_DEPTH) @(negedge clk);
        wait_cycles(100);
        check_value("rx held while full", RX_DEPTH, rx_count);
        read_rx_bytes("receive order", BURST);
        wait_cycles(100);
        check_value("rx nothing repeated", 1, rx_empty);
        check_value("rx source drained", 0, model.source_size());

        enter_power_save();
        quiet_window = 1'b1;
        sink_before  = model.sink_size();
        send_tx_random(8, 1'b1);
        offer_rx_random(8, 1'b1);
        wait_cycles(200);
        check_value("no tx during power saving", sink_before, model.sink_size());
        check_value("no rx during power saving", 0, rx_count);
        quiet_window = 1'b0;
        model.set_power_save(1'b0);
        check_tx_sink("transmit after power saving");
        check_value("pwrsav after power saving", 0, pwrsav);
        read_rx_bytes("receive after power saving", 8);

        // fill rx plus one held byte and fill tx under power saving before the flush.
        offer_rx_random(RX_DEPTH + 1, 1'b0);
        while ((rx_count != RX_DEPTH) || (model.source_size() != 0)) @(negedge clk);
        wait_cycles(20);
        enter_power_save();
        send_tx_random(TX_DEPTH, 1'b0);
        check_value("tx queued before flush", TX_DEPTH, tx_count);
        check_value("tx full before flush", 1, tx_full);
        fifo_flush = 1'b1;
        @(negedge clk);
        fifo_flush = 1'b0;
        check_value("flush busy raised", 1, fifo_flush_busy);
        while (fifo_flush_busy) @(negedge clk);
        wait_cycles(2);
        check_value("rx count after flush", 0, rx_count);
        check_value("tx count after flush", 0, tx_count);
        check_value("tx full after flush", 0, tx_full);
        model.set_power_save(1'b0);
        wait_cycles(200);
        check_value("held rx byte flushed", 1, rx_empty);
        check_value("flushed tx bytes not sent", tx_expect.size(), model.sink_size());

        model.set_modem_status(8'h01);
        wait_reset_state(1'b1, "reset state set");
        model.set_modem_status(8'h00);
        wait_reset_state(1'b0, "reset state clear");
        ack_and_check_reply(1'b1, "reset reply on");
        ack_and_check_reply(1'b0, "reset reply off");

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule
